/* hw/bilinearBlend.sv */
// Bilinear blend of a texel quad, first along s, then along t
`timescale 1ns/1ps

module bilinearBlend
    import texPkg::*;
(
    input  logic                  aclk,
    input  texelQuad_t            quad,
    input  subCoord_t             subCoord,
    output logic [pixelWidth-1:0] color
);

    // a * (256 - w) + b * w, then >> 8
    function automatic logic [channelWidth-1:0] lerpChannel(
        input logic [channelWidth-1:0] a,
        input logic [channelWidth-1:0] b,
        input logic [weightWidth-1:0]  w
    );
        logic [weightWidth:0]              wInv;
        logic [channelWidth+weightWidth:0] sum;
        wInv = {1'b1, {weightWidth{1'b0}}} - {1'b0, w};
        // Max 255 * 256, no overflow at this width
        sum = a * wInv + b * w;
        lerpChannel = sum[channelWidth+weightWidth-1:weightWidth];
    endfunction

    // Same weight for every channel of RGBA
    function automatic logic [pixelWidth-1:0] lerpPixel(
        input logic [pixelWidth-1:0]  a,
        input logic [pixelWidth-1:0]  b,
        input logic [weightWidth-1:0] w
    );
        logic [pixelWidth-1:0] result;
        result = '0;
        for (int ch = 0; ch < channelCount; ch++)
        begin
            result[ch*channelWidth +: channelWidth] = lerpChannel(
                a[ch*channelWidth +: channelWidth],
                b[ch*channelWidth +: channelWidth],
                w);
        end
        lerpPixel = result;
    endfunction

    // Weights are the top bits of each fraction
    logic [weightWidth-1:0] weightS;
    logic [weightWidth-1:0] weightT;

    assign weightS = subCoord.fracS[fracWidth-1 -: weightWidth];
    assign weightT = subCoord.fracT[fracWidth-1 -: weightWidth];

    //////////////////////////////////////////////////
    // Stage 1: blend along s
    //////////////////////////////////////////////////

    logic [pixelWidth-1:0]  topRow;
    logic [pixelWidth-1:0]  bottomRow;
    logic [weightWidth-1:0] weightTBlend;

    always_ff @(posedge aclk)
    begin
        // Row t0
        topRow       <= lerpPixel(quad.t00, quad.t01, weightS);
        // Row t1
        bottomRow    <= lerpPixel(quad.t10, quad.t11, weightS);
        // Carried along for the second stage
        weightTBlend <= weightT;
    end

    //////////////////////////////////////////////////
    // Stage 2: blend along t
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        color <= lerpPixel(topRow, bottomRow, weightTBlend);
    end

endmodule

/* hw/texPkg.sv */
// Texture unit package: widths, delays, wrap-mode enum, config and sample structs

package texPkg;

    //////////////////////////////////////////////////
    // Widths and delays
    //////////////////////////////////////////////////

    // Texel word address, 256x256 texels max
    localparam int texAddrWidth  = 16;
    localparam int texMemWords   = 1 << texAddrWidth;
    // RGBA8888 texel
    localparam int pixelWidth    = 32;
    localparam int channelWidth  = 8;
    localparam int channelCount  = pixelWidth / channelWidth;
    // S16.15 coordinates
    localparam int coordWidth    = 32;
    localparam int coordFracBits = 15;
    // Q0.16 sub-texel fraction, top bits form the blend weight
    localparam int fracWidth     = 16;
    localparam int weightWidth   = 8;
    // Texture size as log2 per axis, 0..8
    localparam int sizeLog2Width = 4;
    localparam int maxSizeLog2   = 8;
    // Texture RAM read latency
    localparam int memDelay      = 1;
    // Sampler 3 + blend 2
    localparam int latency       = 5;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef enum logic
    {
        wrapRepeat      = 1'b0,
        wrapClampToEdge = 1'b1
    } wrapMode_e;

    typedef struct packed
    {
        logic [sizeLog2Width-1:0] sizeLog2S;
        logic [sizeLog2Width-1:0] sizeLog2T;
        wrapMode_e                wrapS;
        wrapMode_e                wrapT;
        logic                     halfPixelOffset;
    } texConfig_t;

    typedef struct packed
    {
        logic [coordWidth-1:0] s;
        logic [coordWidth-1:0] t;
    } texCoord_t;

    // First digit is the t offset, second the s offset
    typedef struct packed
    {
        logic [pixelWidth-1:0] t00;
        logic [pixelWidth-1:0] t01;
        logic [pixelWidth-1:0] t10;
        logic [pixelWidth-1:0] t11;
    } texelQuad_t;

    typedef struct packed
    {
        logic [texAddrWidth-1:0] a00;
        logic [texAddrWidth-1:0] a01;
        logic [texAddrWidth-1:0] a10;
        logic [texAddrWidth-1:0] a11;
    } quadAddr_t;

    typedef struct packed
    {
        logic [fracWidth-1:0] fracS;
        logic [fracWidth-1:0] fracT;
    } subCoord_t;

endpackage

/* hw/texQuadMemory.sv */
// Texture RAM: one write port, four fixed-latency read ports
`timescale 1ns/1ps

module texQuadMemory
    import texPkg::*;
(
    input  logic                    aclk,
    input  logic                    wrEn,
    input  logic [texAddrWidth-1:0] wrAddr,
    input  logic [pixelWidth-1:0]   wrData,
    input  quadAddr_t               rdAddr,
    output texelQuad_t              rdData
);

    // Full 256x256 texel store
    logic [pixelWidth-1:0] mem [texMemWords];

    // Read pipeline, last stage drives rdData
    texelQuad_t readStage [memDelay];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (wrEn)
        begin
            mem[wrAddr] <= wrData;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Old data on a same-cycle write, new data one cycle later
    always_ff @(posedge aclk)
    begin
        readStage[0].t00 <= mem[rdAddr.a00];
        readStage[0].t01 <= mem[rdAddr.a01];
        readStage[0].t10 <= mem[rdAddr.a10];
        readStage[0].t11 <= mem[rdAddr.a11];
        // Extra stages for longer latency
        for (int i = 1; i < memDelay; i++)
        begin
            readStage[i] <= readStage[i-1];
        end
    end

    assign rdData = readStage[memDelay-1];

endmodule

/* hw/texelQuadSampler.sv */
// Texel quad sampler: quad addressing, sub-texel fractions, clamp flags, edge correction
`timescale 1ns/1ps

module texelQuadSampler
    import texPkg::*;
(
    input  logic       aclk,
    input  logic       rstN,
    input  texConfig_t cfg,
    input  texCoord_t  coord,
    output quadAddr_t  quadAddr,
    input  texelQuad_t quadData,
    output texelQuad_t quad,
    output subCoord_t  subCoord
);

    // One texel or half a texel in S16.15, size dependent
    function automatic logic [coordWidth-1:0] texelStep(
        input logic [sizeLog2Width-1:0] sizeLog2,
        input logic                     half
    );
        logic [coordWidth-1:0] one;
        one = {{(coordWidth-1){1'b0}}, 1'b1};
        if (half)
            texelStep = one << (coordFracBits - 1 - sizeLog2);
        else
            texelStep = one << (coordFracBits - sizeLog2);
    endfunction

    // Non-negative with a nonzero integer part
    function automatic logic aboveEdge(input logic [coordWidth-1:0] c);
        aboveEdge = !c[coordWidth-1] && (c[coordWidth-2:coordFracBits] != '0);
    endfunction

    // Reduce to Q1.15, saturating at the edges in clamp mode
    function automatic logic [fracWidth-1:0] clampCoord(
        input logic [coordWidth-1:0] c,
        input wrapMode_e             mode
    );
        // Repeat just keeps the fraction (plus integer LSB)
        clampCoord = c[fracWidth-1:0];
        if (mode == wrapClampToEdge)
        begin
            // Sign bit set means below 0
            if (c[coordWidth-1])
                clampCoord = '0;
            // Just below 1.0
            else if (aboveEdge(c))
                clampCoord = {1'b0, {(fracWidth-1){1'b1}}};
        end
    endfunction

    // Texel index from the top fraction bits
    function automatic logic [maxSizeLog2-1:0] texelIndex(
        input logic [fracWidth-1:0]     q,
        input logic [sizeLog2Width-1:0] sizeLog2
    );
        texelIndex = q[coordFracBits-1 -: maxSizeLog2] >> (maxSizeLog2 - sizeLog2);
    endfunction

    // Row shifted by the width, ORed with the column
    function automatic logic [texAddrWidth-1:0] texelAddr(
        input logic [maxSizeLog2-1:0]   row,
        input logic [maxSizeLog2-1:0]   col,
        input logic [sizeLog2Width-1:0] sizeLog2S
    );
        texelAddr = (texAddrWidth'(row) << sizeLog2S) | texAddrWidth'(col);
    endfunction

    // Position inside the texel as Q0.16
    function automatic logic [fracWidth-1:0] subFraction(
        input logic [fracWidth-1:0]     q,
        input logic [sizeLog2Width-1:0] sizeLog2
    );
        subFraction = {q[coordFracBits-1:0], 1'b0} << sizeLog2;
    endfunction

    //////////////////////////////////////////////////
    // Stage 0: quad addresses
    //////////////////////////////////////////////////

    logic [coordWidth-1:0]  stepS;
    logic [coordWidth-1:0]  stepT;
    // Raw S16.15 quad corners
    logic [coordWidth-1:0]  s0Raw;
    logic [coordWidth-1:0]  s1Raw;
    logic [coordWidth-1:0]  t0Raw;
    logic [coordWidth-1:0]  t1Raw;
    // Wrapped or clamped, Q1.15
    logic [fracWidth-1:0]   s0;
    logic [fracWidth-1:0]   s1;
    logic [fracWidth-1:0]   t0;
    logic [fracWidth-1:0]   t1;
    logic [maxSizeLog2-1:0] col0;
    logic [maxSizeLog2-1:0] col1;
    logic [maxSizeLog2-1:0] row0;
    logic [maxSizeLog2-1:0] row1;

    always_comb
    begin
        stepS = texelStep(cfg.sizeLog2S, cfg.halfPixelOffset);
        stepT = texelStep(cfg.sizeLog2T, cfg.halfPixelOffset);
        // Offset on: half a texel each way
        if (cfg.halfPixelOffset)
        begin
            s0Raw = coord.s - stepS;
            t0Raw = coord.t - stepT;
        end
        else
        begin
            s0Raw = coord.s;
            t0Raw = coord.t;
        end
        s1Raw = coord.s + stepS;
        t1Raw = coord.t + stepT;

        s0 = clampCoord(s0Raw, cfg.wrapS);
        s1 = clampCoord(s1Raw, cfg.wrapS);
        t0 = clampCoord(t0Raw, cfg.wrapT);
        t1 = clampCoord(t1Raw, cfg.wrapT);

        col0 = texelIndex(s0, cfg.sizeLog2S);
        col1 = texelIndex(s1, cfg.sizeLog2S);
        row0 = texelIndex(t0, cfg.sizeLog2T);
        row1 = texelIndex(t1, cfg.sizeLog2T);
    end

    subCoord_t subCoordAddr;
    logic      clampSAddr;
    logic      clampTAddr;

    always_ff @(posedge aclk)
    begin
        quadAddr.a00 <= texelAddr(row0, col0, cfg.sizeLog2S);
        quadAddr.a01 <= texelAddr(row0, col1, cfg.sizeLog2S);
        quadAddr.a10 <= texelAddr(row1, col0, cfg.sizeLog2S);
        quadAddr.a11 <= texelAddr(row1, col1, cfg.sizeLog2S);
        // Fraction of the first corner weights the quad
        subCoordAddr.fracS <= subFraction(s0, cfg.sizeLog2S);
        subCoordAddr.fracT <= subFraction(t0, cfg.sizeLog2T);
        // Second corner ran over the far edge
        clampSAddr <= (cfg.wrapS == wrapClampToEdge) && aboveEdge(s1Raw);
        clampTAddr <= (cfg.wrapT == wrapClampToEdge) && aboveEdge(t1Raw);
    end

    //////////////////////////////////////////////////
    // Stage 1: wait for the texture RAM
    //////////////////////////////////////////////////

    subCoord_t subCoordRead;
    logic      clampSRead;
    logic      clampTRead;

    valueDelay #(.valueType(subCoord_t), .depth(memDelay)) subCoordDelay (
        .aclk (aclk),
        .rstN (rstN),
        .in   (subCoordAddr),
        .out  (subCoordRead)
    );

    valueDelay #(.valueType(logic), .depth(memDelay)) clampSDelay (
        .aclk (aclk),
        .rstN (rstN),
        .in   (clampSAddr),
        .out  (clampSRead)
    );

    valueDelay #(.valueType(logic), .depth(memDelay)) clampTDelay (
        .aclk (aclk),
        .rstN (rstN),
        .in   (clampTAddr),
        .out  (clampTRead)
    );

    //////////////////////////////////////////////////
    // Stage 2: edge correction
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        subCoord <= subCoordRead;
        quad.t00 <= quadData.t00;
        // Flagged axis falls back to the base texel
        quad.t01 <= clampSRead ? quadData.t00 : quadData.t01;
        quad.t10 <= clampTRead ? quadData.t00 : quadData.t10;
        if (clampSRead)
            quad.t11 <= clampTRead ? quadData.t00 : quadData.t10;
        else
            quad.t11 <= clampTRead ? quadData.t01 : quadData.t11;
    end

endmodule

/* hw/textureUnit.sv */
// Texture unit top: sampler, texture RAM, bilinear blend and valid delay line
`timescale 1ns/1ps

module textureUnit
    import texPkg::*;
(
    input  logic                    aclk,
    input  logic                    rstN,
    input  texConfig_t              cfg,
    // One sample per cycle, no back-pressure
    input  logic                    sampleValid,
    input  texCoord_t               coord,
    // Texture load port
    input  logic                    memWrEn,
    input  logic [texAddrWidth-1:0] memWrAddr,
    input  logic [pixelWidth-1:0]   memWrData,
    // Blended RGBA8888, latency cycles after the sample
    output logic                    colorValid,
    output logic [pixelWidth-1:0]   color
);

    quadAddr_t  quadAddr;
    texelQuad_t quadData;
    // Edge-corrected quad and its fractions
    texelQuad_t quad;
    subCoord_t  subCoord;

    texelQuadSampler sampler (
        .aclk     (aclk),
        .rstN     (rstN),
        .cfg      (cfg),
        .coord    (coord),
        .quadAddr (quadAddr),
        .quadData (quadData),
        .quad     (quad),
        .subCoord (subCoord)
    );

    texQuadMemory texMem (
        .aclk   (aclk),
        .wrEn   (memWrEn),
        .wrAddr (memWrAddr),
        .wrData (memWrData),
        .rdAddr (quadAddr),
        .rdData (quadData)
    );

    bilinearBlend blend (
        .aclk     (aclk),
        .quad     (quad),
        .subCoord (subCoord),
        .color    (color)
    );

    // Strobe follows the datapath, cleared by reset
    valueDelay #(.valueType(logic), .depth(latency)) validDelay (
        .aclk (aclk),
        .rstN (rstN),
        .in   (sampleValid),
        .out  (colorValid)
    );

endmodule

/* hw/valueDelay.sv */
// Fixed-length register chain delaying a packed value
`timescale 1ns/1ps

module valueDelay #(
    parameter type valueType = logic,
    parameter int  depth     = 1
)
(
    input  logic     aclk,
    input  logic     rstN,
    input  valueType in,
    output valueType out
);

    // Stage 0 takes the input, last stage drives the output
    valueType chain [depth];

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            // Whole chain cleared so delayed strobes start low
            for (int i = 0; i < depth; i++)
            begin
                chain[i] <= '0;
            end
        end
        else
        begin
            chain[0] <= in;
            for (int i = 1; i < depth; i++)
            begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign out = chain[depth-1];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the texture unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f textureUnit.f --top-module textureUnitTb -o textureUnitSim

# Keep running past assertion errors so the testbench prints its verdict
simOutput=$(./obj_dir/textureUnitSim +verilator+error+limit+1000 2>&1) || true
echo "$simOutput"

if grep -q "TEST PASSED" <<< "$simOutput"; then
    exit 0
fi
exit 1

/* textureUnit.f */
hw/texPkg.sv
hw/valueDelay.sv
hw/texelQuadSampler.sv
hw/texQuadMemory.sv
hw/bilinearBlend.sv
hw/textureUnit.sv
verif/textureUnit_chk.sv
verif/textureUnitTb.sv

/* verif/textureUnitTb.sv */
// Texture unit testbench: clock, reset, texture load, directed and random samples, reference model
`timescale 1ns/1ps

module textureUnitTb
    import texPkg::*;
();

    localparam int randomSeed  = 54921;
    localparam int resetCycles = 16;
    localparam int drainLimit  = latency + 20;
    // Fill pattern bias per channel, byte 0 first
    localparam logic [7:0] channelBias [channelCount] = '{8'h00, 8'h5A, 8'hA5, 8'h3C};
    // Clamp test coordinates, two below 0 and three at or above 1.0
    localparam int edgeCoord [5] = '{-9830, -65536, 32768, 40960, 114688};

    logic                    aclk;
    logic                    rstN;
    texConfig_t              cfg;
    logic                    sampleValid;
    texCoord_t               coord;
    logic                    memWrEn;
    logic [texAddrWidth-1:0] memWrAddr;
    logic [pixelWidth-1:0]   memWrData;
    logic                    colorValid;
    logic [pixelWidth-1:0]   color;

    // Expected colours, oldest first
    logic [pixelWidth-1:0] expectQueue [$];
    string                 currentTest;
    int                    errorCount;
    int                    testErrors;
    int                    testCount;
    int                    testsFailed;

    textureUnit uut (
        .aclk        (aclk),
        .rstN        (rstN),
        .cfg         (cfg),
        .sampleValid (sampleValid),
        .coord       (coord),
        .memWrEn     (memWrEn),
        .memWrAddr   (memWrAddr),
        .memWrData   (memWrData),
        .colorValid  (colorValid),
        .color       (color)
    );

    bind textureUnit textureUnit_chk chk (
        .aclk        (aclk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .colorValid  (colorValid)
    );

    // 20 ns period
    always #10 aclk = ~aclk;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Each channel is the low address byte plus its bias
    function automatic logic [pixelWidth-1:0] texelAt(input int addr);
        logic [pixelWidth-1:0] texel;
        for (int ch = 0; ch < channelCount; ch++)
        begin
            texel[ch*channelWidth +: channelWidth] = channelWidth'(addr + channelBias[ch]);
        end
        return texel;
    endfunction

    // Position inside the texture as Q0.15
    function automatic int unitCoord(input int c, input wrapMode_e mode);
        if (mode == wrapRepeat)
            return c & 32'h7FFF;
        if (c < 0)
            return 0;
        if (c >= 32768)
            return 32767;
        return c;
    endfunction

    // a * (256 - w) + b * w, then >> 8, per channel
    function automatic logic [pixelWidth-1:0] blendPixel(
        input logic [pixelWidth-1:0] a,
        input logic [pixelWidth-1:0] b,
        input int                    w
    );
        logic [pixelWidth-1:0] mixed;
        int                    ca;
        int                    cb;
        for (int ch = 0; ch < channelCount; ch++)
        begin
            ca = a[ch*channelWidth +: channelWidth];
            cb = b[ch*channelWidth +: channelWidth];
            mixed[ch*channelWidth +: channelWidth] = channelWidth'((ca * (256 - w) + cb * w) >> 8);
        end
        return mixed;
    endfunction

    function automatic logic [pixelWidth-1:0] modelColor(input texConfig_t c, input texCoord_t p);
        int                    lgS;
        int                    lgT;
        int                    s0;
        int                    s1;
        int                    t0;
        int                    t1;
        logic                  clampS;
        logic                  clampT;
        logic [pixelWidth-1:0] q00;
        logic [pixelWidth-1:0] q01;
        logic [pixelWidth-1:0] q10;
        logic [pixelWidth-1:0] q11;
        lgS = c.sizeLog2S;
        lgT = c.sizeLog2T;
        // Corners one texel apart, or half a texel each way
        s0 = int'(p.s) - (c.halfPixelOffset ? (1 << (14 - lgS)) : 0);
        t0 = int'(p.t) - (c.halfPixelOffset ? (1 << (14 - lgT)) : 0);
        s1 = int'(p.s) + (c.halfPixelOffset ? (1 << (14 - lgS)) : (1 << (15 - lgS)));
        t1 = int'(p.t) + (c.halfPixelOffset ? (1 << (14 - lgT)) : (1 << (15 - lgT)));
        // Far corner ran past 1.0 on a clamped axis
        clampS = (c.wrapS == wrapClampToEdge) && (s1 >= 32768);
        clampT = (c.wrapT == wrapClampToEdge) && (t1 >= 32768);
        s0 = unitCoord(s0, c.wrapS);
        s1 = unitCoord(s1, c.wrapS);
        t0 = unitCoord(t0, c.wrapT);
        t1 = unitCoord(t1, c.wrapT);
        q00 = texelAt(((t0 >> (15 - lgT)) << lgS) | (s0 >> (15 - lgS)));
        q01 = texelAt(((t0 >> (15 - lgT)) << lgS) | (s1 >> (15 - lgS)));
        q10 = texelAt(((t1 >> (15 - lgT)) << lgS) | (s0 >> (15 - lgS)));
        q11 = texelAt(((t1 >> (15 - lgT)) << lgS) | (s1 >> (15 - lgS)));
        // Clamped neighbours fall back to the base texel
        if (clampS)
        begin
            q01 = q00;
            q11 = q10;
        end
        if (clampT)
        begin
            q10 = q00;
            q11 = q01;
        end
        // Weights are the top byte of the Q0.16 fraction of corner 0
        return blendPixel(blendPixel(q00, q01, ((s0 << (lgS + 1)) & 32'hFFFF) >> 8),
                          blendPixel(q10, q11, ((s0 << (lgS + 1)) & 32'hFFFF) >> 8),
                          ((t0 << (lgT + 1)) & 32'hFFFF) >> 8);
    endfunction

    function automatic texConfig_t makeConfig(input int lgS, input int lgT,
                                              input wrapMode_e wS, input wrapMode_e wT,
                                              input logic half);
        texConfig_t c;
        c.sizeLog2S       = sizeLog2Width'(lgS);
        c.sizeLog2T       = sizeLog2Width'(lgT);
        c.wrapS           = wS;
        c.wrapT           = wT;
        c.halfPixelOffset = half;
        return c;
    endfunction

    function automatic texCoord_t coordOf(input int s, input int t);
        texCoord_t p;
        p.s = s;
        p.t = t;
        return p;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and reporting
    //////////////////////////////////////////////////

    task automatic noteError();
        errorCount++;
        testErrors++;
    endtask

    task automatic beginTest(input string name);
        currentTest = name;
        testErrors  = 0;
    endtask

    task automatic sendSample(input texConfig_t c, input texCoord_t p,
                              input logic [pixelWidth-1:0] expected);
        @(negedge aclk);
        cfg         = c;
        coord       = p;
        sampleValid = 1'b1;
        expectQueue.push_back(expected);
    endtask

    // Fill 256 words while colorValid must stay low
    task automatic loadTexture();
        for (int a = 0; a < 256; a++)
        begin
            @(negedge aclk);
            memWrEn   = 1'b1;
            memWrAddr = texAddrWidth'(a);
            memWrData = texelAt(a);
            assert (colorValid === 1'b0)
            else
            begin
                $display("colorValid went high before any sample was sent");
                noteError();
            end
        end
        @(negedge aclk);
        memWrEn = 1'b0;
    endtask

    // Stop sampling, let the pipeline empty, print the result line
    task automatic endTest();
        int waited;
        waited = 0;
        @(negedge aclk);
        sampleValid = 1'b0;
        while (expectQueue.size() != 0 && waited < drainLimit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (expectQueue.size() != 0)
        begin
            $display("Timeout in %s: %0d colours never came out", currentTest, expectQueue.size());
            noteError();
            expectQueue.delete();
        end
        testCount++;
        if (testErrors != 0)
            testsFailed++;
        $display("%s: %s, %0d errors", currentTest, (testErrors == 0) ? "ok" : "failed",
                 testErrors);
    endtask

    // Outputs sampled at the clock edge, before the DUT updates them
    always @(posedge aclk)
    begin : outputMonitor
        logic [pixelWidth-1:0] expected;
        if (rstN === 1'b1 && colorValid === 1'b1)
        begin
            if (expectQueue.size() == 0)
            begin
                $display("colorValid in %s without a pending sample", currentTest);
                noteError();
            end
            else
            begin
                expected = expectQueue.pop_front();
                assert (color === expected)
                else
                begin
                    $display("[FAIL] %s expected %h actual %h", currentTest, expected, color);
                    noteError();
                end
            end
        end
    end

    initial
    begin
        texConfig_t cfgA;
        texCoord_t  p;
        aclk        = 1'b0;
        rstN        = 1'b0;
        cfg         = '0;
        sampleValid = 1'b0;
        coord       = '0;
        memWrEn     = 1'b0;
        memWrAddr   = '0;
        memWrData   = '0;
        errorCount  = 0;
        testCount   = 0;
        testsFailed = 0;
        void'($urandom(randomSeed));

        beginTest("reset");
        repeat (resetCycles)
        begin
            @(negedge aclk);
            assert (colorValid === 1'b0)
            else
            begin
                $display("colorValid not low during reset");
                noteError();
            end
        end
        rstN = 1'b1;
        loadTexture();
        endTest();

        // Texel centres, s shifted by whole turns to exercise repeat
        beginTest("repeat_centred");
        cfgA = makeConfig(3, 3, wrapRepeat, wrapRepeat, 1'b0);
        for (int row = 0; row < 8; row++)
        begin
            for (int col = 0; col < 8; col++)
            begin
                sendSample(cfgA, coordOf((col << 12) + (row - 4) * 32768, row << 12),
                           texelAt((row << 3) | col));
            end
        end
        endTest();

        // Outside [0, 1) on both axes, any fraction gives the edge texel
        beginTest("clamp_edge");
        for (int i = 0; i < 5; i++)
        begin
            for (int j = 0; j < 5; j++)
            begin
                cfgA = makeConfig(3, 3, wrapClampToEdge, wrapClampToEdge, 1'((i + j) % 2));
                sendSample(cfgA, coordOf(edgeCoord[i], edgeCoord[j]),
                           texelAt(((edgeCoord[j] < 0) ? 0 : 56) | ((edgeCoord[i] < 0) ? 0 : 7)));
            end
        end
        endTest();

        // Between centres, four distinct texels
        beginTest("bilinear_half_pixel");
        cfgA = makeConfig(3, 3, wrapRepeat, wrapClampToEdge, 1'b1);
        for (int i = 0; i < 16; i++)
        begin
            p = coordOf(((i % 7) << 12) + 2048 + ((i % 4) << 10) + 256,
                        (((i * 3) % 7) << 12) + 2048 + (((i + 1) % 4) << 10) + 512);
            sendSample(cfgA, p, modelColor(cfgA, p));
        end
        endTest();

        // Back to back, new random config every 20 samples
        beginTest("random_pipelined");
        for (int i = 0; i < 200; i++)
        begin
            if (i % 20 == 0)
                cfgA = makeConfig($urandom_range(3), $urandom_range(3),
                                  wrapMode_e'($urandom_range(1)), wrapMode_e'($urandom_range(1)),
                                  1'($urandom_range(1)));
            p = coordOf(int'($urandom_range(65535)) - 16384, int'($urandom_range(65535)) - 16384);
            sendSample(cfgA, p, modelColor(cfgA, p));
        end
        endTest();

        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 testCount, testsFailed, errorCount, uut.chk.failCount);
        if (errorCount == 0 && uut.chk.failCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* verif/textureUnit_chk.sv */
// Bound checker: colorValid reset state and sample-to-colour latency
`timescale 1ns/1ps

module textureUnit_chk
    import texPkg::*;
(
    input logic aclk,
    input logic rstN,
    input logic sampleValid,
    input logic colorValid
);

    // Failed assertions, summed up by the testbench
    int unsigned failCount = 0;

    //////////////////////////////////////////////////
    // Reset state
    //////////////////////////////////////////////////

    // Low in reset and in the first cycle after it
    resetQuiet: assert property (@(posedge aclk) !rstN |=> !colorValid)
    else
    begin
        failCount++;
        $error("colorValid high during or right after reset");
    end

    //////////////////////////////////////////////////
    // Valid latency
    //////////////////////////////////////////////////

    // Every sample comes out exactly latency cycles later
    sampleToColor: assert property (@(posedge aclk) disable iff (!rstN)
        $past(sampleValid, latency) |-> colorValid)
    else
    begin
        failCount++;
        $error("sample without colorValid %0d cycles later", latency);
    end

    // No colour without a matching sample
    colorFromSample: assert property (@(posedge aclk) disable iff (!rstN)
        $rose(colorValid) |-> $past(sampleValid, latency))
    else
    begin
        failCount++;
        $error("colorValid rose without an earlier sample");
    end

endmodule
